/* list.f */
+incdir+verilog
verilog/busPkg.sv
verilog/inputPkg.sv
verilog/busIf.sv
verilog/debounceBank.sv
verilog/cycleStrobe.sv
verilog/mainMemory.sv
verilog/addressDecoder.sv
verilog/periphTop.sv
bench/periphBench.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the peripheral block testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module periphBench -f list.f

output=$(./obj_dir/VperiphBench)
echo "$output"

if grep -qF 'All tests passed!' <<< "$output"; then
    exit 0
else
    exit 1
fi

/* bench/periphBench.sv */
// console peripheral block testbench
// directed tests for bus strobe, main memory, write gating and input debouncing
`timescale 1ns/10ps
`default_nettype none
`include "periph_params.svh"

module periphBench
    import busPkg::*;
    import inputPkg::*;
();

    // worst case cycles per test, watchdog allows twice the sum
    localparam int WRITE_CYCLES = 2 * `STROBE_DIVIDE + 2;
    localparam int TEST_CYCLES  = 10 + (4 * `STROBE_DIVIDE + 4)
        + (64 * WRITE_CYCLES + 128 * 2) + (3 * `STROBE_DIVIDE + WRITE_CYCLES + 8)
        + (3 * `DEBOUNCE_CYCLES + 20) + (2 * `DEBOUNCE_CYCLES + WRITE_CYCLES + 20);
    localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;

    logic         clk;
    logic         rstN;
    addr_t        address;
    data_t        writeData;
    logic         writeEn;
    logic         readEn;
    data_t        readData;
    logic         busStrobe;
    consoleKeys_t consoleRaw;
    triggers_t    triggerRaw;

    data_t  refMem [2 ** `MEM_ADDR_BITS];
    addr_t  wrAddr [64];
    integer seed = 24;

    periphTop UUT (
        .clk        (clk),
        .rstN       (rstN),
        .address    (address),
        .writeData  (writeData),
        .writeEn    (writeEn),
        .readEn     (readEn),
        .readData   (readData),
        .busStrobe  (busStrobe),
        .consoleRaw (consoleRaw),
        .triggerRaw (triggerRaw)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        failRun("simulation ran past the watchdog limit");
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic checkData(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s read %02h, expected %02h", $time, what, got, exp);
            failRun("data mismatch");
        end
    endtask

    task automatic checkBit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
            failRun("bit mismatch");
        end
    endtask

    // negedge sampling, strobe only changes on posedge
    task automatic waitStrobe();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!busStrobe && waited <= 2 * `STROBE_DIVIDE) begin
            waited++;
            @(negedge clk);
        end
        if (!busStrobe) failRun("bus strobe did not arrive");
    endtask

    // hold writeEn as a level until one strobe edge has passed
    task automatic writeByte(input addr_t a, input data_t d);
        @(posedge clk);
        address   <= a;
        writeData <= d;
        readEn    <= 1'b0;
        writeEn   <= 1'b1;
        waitStrobe();
        @(posedge clk);
        writeEn <= 1'b0;
        if (a != `INPUT_REG_ADDR) refMem[a] = d;
    endtask

    task automatic readByte(input addr_t a, output data_t d);
        @(posedge clk);
        address <= a;
        writeEn <= 1'b0;
        readEn  <= 1'b1;
        @(negedge clk);
        d = readData;
    endtask

    task automatic selectInputReg();
        @(posedge clk);
        address <= `INPUT_REG_ADDR;
        writeEn <= 1'b0;
        readEn  <= 1'b1;
    endtask

    task automatic strobeTest();
        // first negedge follows the reset release edge
        @(negedge clk);
        checkBit(busStrobe, 1'b0, "busStrobe after reset");
        checkData(readData, 8'h00, "readData after reset");
        for (int k = 1; k <= 4 * `STROBE_DIVIDE; k++) begin
            @(negedge clk);
            checkBit(busStrobe, (k % `STROBE_DIVIDE) == 0, "busStrobe cadence");
        end
    endtask

    task automatic memoryTest();
        int    r;
        addr_t a;
        data_t got;
        for (int i = 0; i < 64; i++) begin
            r = $random(seed);
            a = r[15:0];
            if (a == `INPUT_REG_ADDR) a = a + 16'h0001;
            wrAddr[i] = a;
            writeByte(a, r[23:16]);
        end
        for (int i = 0; i < 64; i++) begin
            readByte(wrAddr[i], got);
            checkData(got, refMem[wrAddr[i]], "memory readback");
        end
        // neighbours of written bytes, mostly never written
        for (int i = 0; i < 64; i++) begin
            a = wrAddr[i] ^ 16'h0101;
            if (a == `INPUT_REG_ADDR) a = a + 16'h0001;
            readByte(a, got);
            checkData(got, refMem[a], "unwritten address");
        end
    endtask

    task automatic gatingTest();
        data_t got;
        writeByte(16'h0123, 8'h5A);
        waitStrobe();
        // writeEn high only on edges where the strobe is low
        @(posedge clk);
        address   <= 16'h0123;
        writeData <= 8'hA5;
        readEn    <= 1'b0;
        writeEn   <= 1'b1;
        repeat (`STROBE_DIVIDE - 1) begin
            @(negedge clk);
            checkBit(busStrobe, 1'b0, "busStrobe during held write");
            checkData(readData, 8'h00, "readData with readEn low");
            @(posedge clk);
        end
        writeEn <= 1'b0;
        readByte(16'h0123, got);
        checkData(got, 8'h5A, "byte after unstrobed write");
    endtask

    task automatic consoleTest();
        consoleKeys_t keys;
        keys       = '0;
        keys.start = 1'b1;
        selectInputReg();
        @(posedge clk);
        consoleRaw.start <= 1'b1;
        for (int k = 0; k <= `DEBOUNCE_CYCLES + 2; k++) begin
            @(negedge clk);
            checkData(readData, (k >= `DEBOUNCE_CYCLES + 2) ? {4'h0, keys} : 8'h00,
                "console key press");
        end
        @(posedge clk);
        consoleRaw.start <= 1'b0;
        repeat (4) @(negedge clk);
        // glitch one sample short of the debounce length
        for (int k = 0; k <= `DEBOUNCE_CYCLES + 10; k++) begin
            @(posedge clk);
            consoleRaw.select <= (k < `DEBOUNCE_CYCLES - 1);
            @(negedge clk);
            checkData(readData, 8'h00, "console glitch");
        end
    endtask

    task automatic triggerTest();
        triggers_t trig;
        data_t     got;
        trig = 4'b1010;
        selectInputReg();
        @(posedge clk);
        triggerRaw <= trig;
        repeat (`DEBOUNCE_CYCLES + 3) @(negedge clk);
        checkData(readData, {trig, 4'h0}, "trigger press");
        writeByte(`INPUT_REG_ADDR, 8'hFF);
        readByte(`INPUT_REG_ADDR, got);
        checkData(got, {trig, 4'h0}, "input register after write");
        @(posedge clk);
        triggerRaw <= '0;
        for (int k = 0; k <= 3; k++) begin
            @(negedge clk);
            checkData(readData, (k < 3) ? {trig, 4'h0} : 8'h00, "trigger release");
        end
    endtask

    initial begin
        rstN       = 1'b0;
        address    = '0;
        writeData  = '0;
        writeEn    = 1'b0;
        readEn     = 1'b0;
        consoleRaw = '0;
        triggerRaw = '0;
        for (int i = 0; i < 2 ** `MEM_ADDR_BITS; i++) refMem[i] = '0;
        repeat (10) @(posedge clk);
        rstN <= 1'b1;
        strobeTest();
        memoryTest();
        gatingTest();
        consoleTest();
        triggerTest();
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/periphTop.sv */
// console peripheral block
// bus strobe, input debouncing, address decode and main memory
`timescale 1ns/10ps
`default_nettype none
`include "periph_params.svh"

module periphTop
    import busPkg::*;
    import inputPkg::*;
(
    input  wire               clk,
    input  wire               rstN,
    input  wire addr_t        address,
    input  wire data_t        writeData,
    input  wire               writeEn,
    input  wire               readEn,
    output data_t             readData,
    output logic              busStrobe,
    input  wire consoleKeys_t consoleRaw,
    input  wire triggers_t    triggerRaw
);

    consoleKeys_t consoleClean;
    triggers_t    triggerClean;

    // decoder to memory
    busIf memBus ();

    cycleStrobe #(
        .DIVIDE (`STROBE_DIVIDE)
    ) strobeGen (
        .clk    (clk),
        .rstN   (rstN),
        .strobe (busStrobe)
    );

    // same debounce logic for keys and triggers
    debounceBank #(
        .payload_t (consoleKeys_t),
        .CYCLES    (`DEBOUNCE_CYCLES)
    ) consoleDebounce (
        .clk   (clk),
        .rstN  (rstN),
        .raw   (consoleRaw),
        .clean (consoleClean)
    );

    debounceBank #(
        .payload_t (triggers_t),
        .CYCLES    (`DEBOUNCE_CYCLES)
    ) triggerDebounce (
        .clk   (clk),
        .rstN  (rstN),
        .raw   (triggerRaw),
        .clean (triggerClean)
    );

    addressDecoder decoder (
        .clk         (clk),
        .rstN        (rstN),
        .address     (address),
        .writeData   (writeData),
        .writeEn     (writeEn),
        .readEn      (readEn),
        .strobe      (busStrobe),
        .consoleKeys (consoleClean),
        .triggers    (triggerClean),
        .readData    (readData),
        .mem         (memBus.initiator)
    );

    mainMemory memory (
        .clk (clk),
        .bus (memBus.target)
    );

endmodule

`default_nettype wire

/* verilog/addressDecoder.sv */
// bus address decoder
// sends strobed writes to memory, except at the input register
// read mux between input register, memory and zero
`timescale 1ns/10ps
`default_nettype none
`include "periph_params.svh"

module addressDecoder
    import busPkg::*;
    import inputPkg::*;
(
    input  wire               clk,
    input  wire               rstN,
    input  wire addr_t        address,
    input  wire data_t        writeData,
    input  wire               writeEn,
    input  wire               readEn,
    input  wire               strobe,
    input  wire consoleKeys_t consoleKeys,
    input  wire triggers_t    triggers,
    output data_t             readData,
    busIf.initiator           mem
);

    logic  isInputReg;
    data_t inputByte;

    assign isInputReg = (address == `INPUT_REG_ADDR);

    // triggers high nibble, console keys low nibble
    assign inputByte = {triggers, consoleKeys};

    assign mem.address   = address;
    assign mem.writeData = writeData;
    // held write level becomes one pulse per bus cycle
    assign mem.writeEn   = writeEn & strobe & ~isInputReg;
    assign mem.readEn    = readEn & ~isInputReg;

    always_comb begin
        if (!readEn) begin
            readData = '0;
        end else if (isInputReg) begin
            readData = inputByte;
        end else begin
            readData = mem.readData;
        end
    end

    // plain level bus, initiator never asks for both
    noReadWrite: assert property (@(posedge clk) disable iff (!rstN)
        !(writeEn && readEn))
        else $error("writeEn and readEn both high");

endmodule

`default_nettype wire

/* verilog/mainMemory.sv */
// linear main memory
// 64 KB byte array, combinational read, write on the strobed enable
`timescale 1ns/10ps
`default_nettype none
`include "periph_params.svh"

module mainMemory
    import busPkg::*;
(
    input wire   clk,
    busIf.target bus
);

    localparam int DEPTH = 2 ** `MEM_ADDR_BITS;

    logic [`MEM_ADDR_BITS-1:0] index;

    // starts cleared, no preload
    data_t mem [DEPTH] = '{default: '0};

    assign index = bus.address[`MEM_ADDR_BITS-1:0];

    // async read, zero when not selected
    assign bus.readData = bus.readEn ? mem[index] : '0;

    // writeEn is already a one-clock pulse
    always_ff @(posedge clk) begin
        if (bus.writeEn) begin
            mem[index] <= bus.writeData;
        end
    end

    // decoder keeps the input register out of memory
    noInputRegWrite: assert property (@(posedge clk)
        bus.writeEn |-> (bus.address != `INPUT_REG_ADDR))
        else $error("memory write at input register address");

endmodule

`default_nettype wire

/* verilog/cycleStrobe.sv */
// bus cycle strobe
// one-clock enable every DIVIDE clocks, in place of a divided clock
`timescale 1ns/10ps
`default_nettype none
`include "periph_params.svh"

module cycleStrobe #(
    parameter int DIVIDE = `STROBE_DIVIDE
) (
    input  wire  clk,
    input  wire  rstN,
    output logic strobe
);

    localparam int CW = (DIVIDE > 1) ? $clog2(DIVIDE) : 1;

    logic [CW-1:0] count;

    // counts 0 .. DIVIDE-1, strobe registered on the wrap
    // first pulse lands DIVIDE edges after reset
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            count  <= '0;
            strobe <= 1'b0;
        end else if (count == CW'(DIVIDE - 1)) begin
            count  <= '0;
            strobe <= 1'b1;
        end else begin
            count  <= count + 1'b1;
            strobe <= 1'b0;
        end
    end

    singlePulse: assert property (@(posedge clk) disable iff (!rstN)
        strobe |=> !strobe)
        else $error("bus strobe high on two consecutive clocks");

endmodule

`default_nettype wire

/* verilog/debounceBank.sv */
// debounce bank
// per bit: two-flop synchronizer, then a counter that saturates at CYCLES
// output bit is high while the counter is saturated
`timescale 1ns/10ps
`default_nettype none
`include "periph_params.svh"

module debounceBank #(
    parameter type payload_t = logic [3:0],
    parameter int  CYCLES    = `DEBOUNCE_CYCLES
) (
    input  wire           clk,
    input  wire           rstN,
    input  wire payload_t raw,
    output payload_t      clean
);

    localparam int W  = $bits(payload_t);
    // wide enough to hold CYCLES itself
    localparam int CW = $clog2(CYCLES + 1);

    logic [W-1:0] rawBits;
    logic [W-1:0] syncA;
    logic [W-1:0] syncB;
    logic [W-1:0] cleanBits;

    assign rawBits = raw;

    // raw keys are asynchronous to clk
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            syncA <= '0;
            syncB <= '0;
        end else begin
            syncA <= rawBits;
            syncB <= syncA;
        end
    end

    for (genvar i = 0; i < W; i++) begin : gBit
        logic [CW-1:0] count;

        // any low sample restarts the count
        always_ff @(posedge clk or negedge rstN) begin
            if (!rstN) begin
                count <= '0;
            end else if (!syncB[i]) begin
                count <= '0;
            end else if (!cleanBits[i]) begin
                count <= count + 1'b1;
            end
        end

        // saturation flag is the debounced level
        assign cleanBits[i] = (count == CW'(CYCLES));
    end

    assign clean = cleanBits;

    // a press must come from a run of high synchronized samples
    cleanNeedsInput: assert property (@(posedge clk) disable iff (!rstN)
        ((cleanBits & ~$past(cleanBits) & ~$past(syncB)) == '0))
        else $error("debounced bit rose with synchronized input low");

endmodule

`default_nettype wire

/* verilog/busIf.sv */
// bus target interface
// address, write data, read data and enables between the decoder and one target
`timescale 1ns/10ps
`default_nettype none

interface busIf
    import busPkg::*;
();

    addr_t address;
    data_t writeData;
    data_t readData;
    // write pulse, already qualified by the bus strobe
    logic  writeEn;
    // read level, target returns zero while low
    logic  readEn;

    modport initiator (
        output address,
        output writeData,
        output writeEn,
        output readEn,
        input  readData
    );

    modport target (
        input  address,
        input  writeData,
        input  writeEn,
        input  readEn,
        output readData
    );

endinterface

`default_nettype wire

/* verilog/inputPkg.sv */
// console input types
// console key fields and joystick trigger bits
`default_nettype none

package inputPkg;

    // console keys, select in bit 0
    // layout matches the low nibble of the input register
    typedef struct packed {
        logic start;
        logic pause;
        logic reset;
        logic select;
    } consoleKeys_t;

    // one bit per joystick trigger, read as the high nibble
    typedef logic [3:0] triggers_t;

endpackage

`default_nettype wire

/* verilog/busPkg.sv */
// cpu bus types
// 16-bit address and 8-bit data for the 6502-class bus
`default_nettype none

package busPkg;

    // full cpu address space
    typedef logic [15:0] addr_t;

    // one data byte on the bus
    typedef logic [7:0] data_t;

endpackage

`default_nettype wire

/* verilog/periph_params.svh */
// peripheral block parameters
// debounce length, bus cycle divide ratio, memory size and the input register address
`ifndef PERIPH_PARAMS_SVH
`define PERIPH_PARAMS_SVH

// consecutive high samples before a button counts as pressed
`define DEBOUNCE_CYCLES 50

// fast clocks per cpu bus cycle
`define STROBE_DIVIDE 4

// linear main memory, 2**MEM_ADDR_BITS bytes
`define MEM_ADDR_BITS 16

// read-only console keys and triggers byte
// sits inside the memory map, so memory writes there are dropped
`define INPUT_REG_ADDR 16'hC010

`endif
